//--- Bender.yml
package:
  name: simt_alu

export_include_dirs:
  - rtl

sources:
  - rtl/simt_alu_pkg.sv
  - rtl/alu_lane.sv
  - rtl/pipe_stage.sv
  - rtl/mul_unit.sv
  - rtl/alu_unit.sv
  - target: test
    files:
      - verif/alu_unit_tb.sv

//--- rtl/alu_lane.sv
`timescale 1ns/100ps
`include "simt_alu_cfg.svh"

module alu_lane (
    input  simt_alu_pkg::alu_op_e op,
    input  logic                  is_branch,
    input  logic                  is_signed,
    input  logic [`XLEN-1:0]      opa,
    input  logic [`XLEN-1:0]      opb,
    input  logic [`XLEN-1:0]      rs1,
    input  logic [`XLEN-1:0]      rs2,
    output logic [`XLEN-1:0]      result,
    output logic [`XLEN-1:0]      sum,
    output logic                  less,
    output logic                  equal
);
    import simt_alu_pkg::*;

    localparam int SHW = $clog2(`XLEN);

    logic [`XLEN-1:0] cmp_b;
    logic [`XLEN:0]   diff;
    logic [SHW-1:0]   shamt;
    logic [`XLEN:0]   shr_in;
    logic [`XLEN-1:0] shr_out;

    assign sum = opa + opb;

    // Branches always compare against rs2
    assign cmp_b = is_branch ? rs2 : opb;

    // One extra bit so the sign of the difference is the compare result
    assign diff  = {is_signed & rs1[`XLEN-1], rs1} - {is_signed & cmp_b[`XLEN-1], cmp_b};
    assign less  = diff[`XLEN];
    assign equal = (diff[`XLEN-1:0] == '0);

    assign shamt   = opb[SHW-1:0];
    assign shr_in  = {(op == ALU_SRA) & rs1[`XLEN-1], rs1};
    assign shr_out = `XLEN'($signed(shr_in) >>> shamt);   // Logical when top bit is 0

    always_comb begin
        case (op)
            ALU_ADD:  result = sum;
            ALU_SUB:  result = diff[`XLEN-1:0];
            ALU_SLT,
            ALU_SLTU: result = {{(`XLEN-1){1'b0}}, less};
            ALU_AND:  result = rs1 & opb;
            ALU_OR:   result = rs1 | opb;
            ALU_XOR:  result = rs1 ^ opb;
            ALU_SLL:  result = rs1 << shamt;
            ALU_SRL,
            ALU_SRA:  result = shr_out;
            default:  result = sum;
        endcase
    end

endmodule

//--- rtl/alu_unit.sv
`timescale 1ns/100ps
`include "simt_alu_cfg.svh"

module alu_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  simt_alu_pkg::alu_req_t req,
    output logic                   commit_valid,
    input  logic                   commit_ready,
    output simt_alu_pkg::commit_t  commit,
    output logic                   branch_valid,
    output simt_alu_pkg::branch_t  branch
);
    import simt_alu_pkg::*;

    localparam bit HAS_MUL = (`EXT_M_ENABLE != 0);

    typedef struct packed {
        commit_t          c;
        logic             is_br;
        br_op_e           br_op;
        logic             less;
        logic             equal;
        logic [`XLEN-1:0] dest;
    } alu_stage_t;

    logic                    is_branch;
    logic                    to_mul;
    logic                    is_jal;
    logic                    is_signed;
    alu_op_e                 lane_op;
    br_op_e                  br_op;
    lane_word_t              opa;
    lane_word_t              opb;
    lane_word_t              lane_sum;
    lane_word_t              lane_result;
    logic [`NUM_THREADS-1:0] lane_less;
    logic [`NUM_THREADS-1:0] lane_equal;
    commit_t                 req_meta;
    alu_stage_t              alu_d;
    alu_stage_t              alu_q;
    logic                    alu_valid_in;
    logic                    alu_ready_in;
    logic                    alu_valid_out;
    logic                    mul_ready_in;
    logic                    mul_valid_out;
    commit_t                 mul_result;

    assign is_branch = (req.op_class == OP_BR);
    assign to_mul    = HAS_MUL && (req.op_class == OP_MUL);
    assign br_op     = br_op_e'(req.op[2:0]);
    assign lane_op   = is_branch ? ALU_SUB : alu_op_e'(req.op);   // Branch data is rs1 - rs2
    assign is_jal    = is_branch && (br_op == BR_JAL || br_op == BR_JALR);
    assign is_signed = is_branch ? (br_op == BR_BLT || br_op == BR_BGE) : (lane_op == ALU_SLT);

    for (genvar i = 0; i < `NUM_THREADS; i++) begin : g_lane
        assign opa[i] = req.use_pc ? req.pc : req.rs1_data[i];
        assign opb[i] = req.use_imm ? req.imm : req.rs2_data[i];

        alu_lane lane (
            .op        (lane_op),
            .is_branch (is_branch),
            .is_signed (is_signed),
            .opa       (opa[i]),
            .opb       (opb[i]),
            .rs1       (req.rs1_data[i]),
            .rs2       (req.rs2_data[i]),
            .result    (lane_result[i]),
            .sum       (lane_sum[i]),
            .less      (lane_less[i]),
            .equal     (lane_equal[i])
        );
    end

    always_comb begin
        req_meta.uuid  = req.uuid;
        req_meta.wid   = req.wid;
        req_meta.tmask = req.tmask;
        req_meta.pc    = req.pc;
        req_meta.rd    = req.rd;
        req_meta.wb    = req.wb;
        req_meta.data  = is_jal ? {`NUM_THREADS{req.next_pc}} : lane_result;   // Link value
    end

    // Lane tid resolves the branch
    assign alu_d.c     = req_meta;
    assign alu_d.is_br = is_branch;
    assign alu_d.br_op = br_op;
    assign alu_d.less  = lane_less[req.tid];
    assign alu_d.equal = lane_equal[req.tid];
    assign alu_d.dest  = lane_sum[req.tid];

    assign alu_valid_in = req_valid && !to_mul;
    // Load only when the port is free or moving, so a stalled multiply result stays put
    assign alu_ready_in = commit_ready || !commit_valid;
    assign req_ready    = to_mul ? mul_ready_in : alu_ready_in;

    pipe_stage #(.DATAW($bits(alu_stage_t))) alu_reg (
        .clk       (clk),
        .reset     (reset),
        .enable    (alu_ready_in),
        .valid_in  (alu_valid_in),
        .data_in   (alu_d),
        .valid_out (alu_valid_out),
        .data_out  (alu_q)
    );

    if (HAS_MUL) begin : g_mul
        mul_unit mul (
            .clk       (clk),
            .reset     (reset),
            .valid_in  (req_valid && to_mul),
            .ready_in  (mul_ready_in),
            .op        (mul_op_e'(req.op[1:0])),
            .meta      (req_meta),
            .rs1       (req.rs1_data),
            .rs2       (req.rs2_data),
            .valid_out (mul_valid_out),
            .ready_out (commit_ready && !alu_valid_out),   // ALU has priority
            .result    (mul_result)
        );
    end else begin : g_no_mul
        assign mul_ready_in  = 1'b0;
        assign mul_valid_out = 1'b0;
        assign mul_result    = '0;
    end

    assign commit_valid = alu_valid_out || mul_valid_out;
    assign commit       = alu_valid_out ? alu_q.c : mul_result;

    always_comb begin
        case (alu_q.br_op)
            BR_BEQ:           branch.taken = alu_q.equal;
            BR_BNE:           branch.taken = !alu_q.equal;
            BR_BLT, BR_BLTU:  branch.taken = alu_q.less;
            BR_BGE, BR_BGEU:  branch.taken = !alu_q.less;
            default:          branch.taken = 1'b1;   // JAL, JALR
        endcase
    end

    assign branch.wid   = alu_q.c.wid;
    assign branch.dest  = alu_q.dest;
    assign branch_valid = alu_valid_out && commit_ready && alu_q.is_br;

    a_branch_commit: assert property (@(posedge clk) disable iff (reset)
        branch_valid |-> commit_valid && commit_ready);

    a_commit_hold: assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit));

endmodule

//--- rtl/mul_unit.sv
`timescale 1ns/100ps
`include "simt_alu_cfg.svh"

module mul_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     valid_in,
    output logic                     ready_in,
    input  simt_alu_pkg::mul_op_e    op,
    input  simt_alu_pkg::commit_t    meta,
    input  simt_alu_pkg::lane_word_t rs1,
    input  simt_alu_pkg::lane_word_t rs2,
    output logic                     valid_out,
    input  logic                     ready_out,
    output simt_alu_pkg::commit_t    result
);
    import simt_alu_pkg::*;

    typedef logic [`NUM_THREADS-1:0][2*`XLEN-1:0] lane_prod_t;

    typedef struct packed {
        lane_prod_t prod;
        mul_op_e    op;
        commit_t    meta;
    } mul_s1_t;

    mul_s1_t s1_d;
    mul_s1_t s1_q;
    commit_t s2_d;
    logic    s1_valid;
    logic    s1_enable;
    logic    s2_enable;
    logic    a_signed;
    logic    b_signed;

    function automatic logic [2*`XLEN-1:0] wide_mul(input logic [`XLEN-1:0] a,
                                                    input logic [`XLEN-1:0] b,
                                                    input logic sa,
                                                    input logic sb);
        logic signed [`XLEN:0]     ax;
        logic signed [`XLEN:0]     bx;
        logic signed [2*`XLEN+1:0] p;
        ax = {sa & a[`XLEN-1], a};
        bx = {sb & b[`XLEN-1], b};
        p  = ax * bx;
        return p[2*`XLEN-1:0];
    endfunction

    assign a_signed = (op == MUL_MULH) || (op == MUL_MULHSU);
    assign b_signed = (op == MUL_MULH);

    always_comb begin
        s1_d.op   = op;
        s1_d.meta = meta;
        for (int i = 0; i < `NUM_THREADS; i++) begin
            s1_d.prod[i] = wide_mul(rs1[i], rs2[i], a_signed, b_signed);
        end
    end

    // Low half for MUL, high half otherwise
    always_comb begin
        s2_d = s1_q.meta;
        for (int i = 0; i < `NUM_THREADS; i++) begin
            s2_d.data[i] = (s1_q.op == MUL_MUL) ? s1_q.prod[i][`XLEN-1:0]
                                                : s1_q.prod[i][2*`XLEN-1:`XLEN];
        end
    end

    assign s2_enable = ready_out || !valid_out;
    assign s1_enable = s2_enable || !s1_valid;   // Room ahead or empty
    assign ready_in  = s1_enable;

    pipe_stage #(.DATAW($bits(mul_s1_t))) s1_reg (
        .clk       (clk),
        .reset     (reset),
        .enable    (s1_enable),
        .valid_in  (valid_in),
        .data_in   (s1_d),
        .valid_out (s1_valid),
        .data_out  (s1_q)
    );

    pipe_stage #(.DATAW($bits(commit_t))) s2_reg (
        .clk       (clk),
        .reset     (reset),
        .enable    (s2_enable),
        .valid_in  (s1_valid),
        .data_in   (s2_d),
        .valid_out (valid_out),
        .data_out  (result)
    );

    // Source must hold a refused request
    a_in_hold: assert property (@(posedge clk) disable iff (reset)
        valid_in && !ready_in |=> valid_in && $stable(meta.uuid));

endmodule

//--- rtl/pipe_stage.sv
`timescale 1ns/100ps

module pipe_stage #(
    parameter int DATAW = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             enable,
    input  logic             valid_in,
    input  logic [DATAW-1:0] data_in,
    output logic             valid_out,
    output logic [DATAW-1:0] data_out
);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out <= 1'b0;
        end else if (enable) begin
            valid_out <= valid_in;
        end
    end

    // Payload only
    always_ff @(posedge clk) begin
        if (enable) begin
            data_out <= data_in;
        end
    end

    a_valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(valid_out));

endmodule

//--- rtl/simt_alu_cfg.svh
`ifndef SIMT_ALU_CFG_SVH
`define SIMT_ALU_CFG_SVH

`define NUM_THREADS 4   // Lanes per warp
`define NUM_WARPS   4
`define NUM_REGS    32
`define XLEN        32
`define UUID_BITS   8   // Instruction tag

// Derived index widths
`define NW_BITS $clog2(`NUM_WARPS)
`define NR_BITS $clog2(`NUM_REGS)
`define NT_BITS $clog2(`NUM_THREADS)

// Multiply unit present when nonzero
`define EXT_M_ENABLE 1

`endif

//--- rtl/simt_alu_pkg.sv
`include "simt_alu_cfg.svh"

package simt_alu_pkg;

    typedef enum logic [1:0] {
        OP_ALU,
        OP_BR,
        OP_MUL
    } op_class_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
        BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
    } br_op_e;

    typedef enum logic [1:0] {
        MUL_MUL, MUL_MULH, MUL_MULHU, MUL_MULHSU
    } mul_op_e;

    typedef logic [`NUM_THREADS-1:0][`XLEN-1:0] lane_word_t;

    typedef struct packed {
        logic [`UUID_BITS-1:0]   uuid;
        logic [`NW_BITS-1:0]     wid;
        logic [`NUM_THREADS-1:0] tmask;
        logic [`XLEN-1:0]        pc;
        logic [`NR_BITS-1:0]     rd;
        logic                    wb;
        op_class_e               op_class;
        logic [3:0]              op;        // Enum chosen by op_class
        logic                    use_pc;
        logic                    use_imm;
        logic [`XLEN-1:0]        imm;
        logic [`NT_BITS-1:0]     tid;       // Lane that resolves a branch
        logic [`XLEN-1:0]        next_pc;
        lane_word_t              rs1_data;
        lane_word_t              rs2_data;
    } alu_req_t;

    typedef struct packed {
        logic [`UUID_BITS-1:0]   uuid;
        logic [`NW_BITS-1:0]     wid;
        logic [`NUM_THREADS-1:0] tmask;
        logic [`XLEN-1:0]        pc;
        logic [`NR_BITS-1:0]     rd;
        logic                    wb;
        lane_word_t              data;
    } commit_t;

    typedef struct packed {
        logic [`NW_BITS-1:0] wid;
        logic                taken;
        logic [`XLEN-1:0]    dest;
    } branch_t;

endpackage

//--- simt_alu.f
+incdir+rtl
rtl/simt_alu_pkg.sv
rtl/alu_lane.sv
rtl/pipe_stage.sv
rtl/mul_unit.sv
rtl/alu_unit.sv
verif/alu_unit_tb.sv

//--- verif/alu_unit_tb.sv
`timescale 1ns/100ps
`include "simt_alu_cfg.svh"

module alu_unit_tb;
    import simt_alu_pkg::*;

    localparam int TIMEOUT = 200;   // Cycles per wait

    logic     clk = 1'b0;
    logic     reset;
    logic     req_valid;
    logic     req_ready;
    alu_req_t req;
    logic     commit_valid;
    logic     commit_ready;
    commit_t  commit;
    logic     branch_valid;
    branch_t  branch;

    logic [31:0]           lfsr = 32'he7e6_a1fd;
    logic [`UUID_BITS-1:0] next_uuid = '0;
    int                    errors = 0;
    int                    timeouts = 0;
    string                 cur_test = "none";

    // Expected results, one queue per path, in acceptance order
    commit_t exp_alu[$];
    branch_t exp_br[$];
    logic    exp_isbr[$];
    commit_t exp_mul[$];
    commit_t prev_commit;
    logic    prev_stall = 1'b0;

    always #2 clk = ~clk;

    alu_unit dut (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req          (req),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit       (commit),
        .branch_valid (branch_valid),
        .branch       (branch)
    );

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic check(input string what, input logic [255:0] exp, input logic [255:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAIL %s %s: expected %0h actual %0h", cur_test, what, exp, act);
        end
    endtask

    function automatic logic [`XLEN-1:0] alu_ref(alu_op_e op, logic [`XLEN-1:0] a,
                                                 logic [`XLEN-1:0] rs1, logic [`XLEN-1:0] b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return rs1 - b;
            ALU_SLT:  return {{(`XLEN-1){1'b0}}, ($signed(rs1) < $signed(b))};
            ALU_SLTU: return {{(`XLEN-1){1'b0}}, (rs1 < b)};
            ALU_AND:  return rs1 & b;
            ALU_OR:   return rs1 | b;
            ALU_XOR:  return rs1 ^ b;
            ALU_SLL:  return rs1 << b[4:0];
            ALU_SRL:  return rs1 >> b[4:0];
            ALU_SRA:  return $unsigned($signed(rs1) >>> b[4:0]);
            default:  return 'x;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] mul_ref(mul_op_e op, logic [`XLEN-1:0] a,
                                                 logic [`XLEN-1:0] b);
        logic [2*`XLEN-1:0] ax;
        logic [2*`XLEN-1:0] bx;
        logic [2*`XLEN-1:0] p;
        ax = {{`XLEN{a[`XLEN-1] & (op == MUL_MULH || op == MUL_MULHSU)}}, a};
        bx = {{`XLEN{b[`XLEN-1] & (op == MUL_MULH)}}, b};
        p  = ax * bx;   // Low 64 bits of the extended product
        return (op == MUL_MUL) ? p[`XLEN-1:0] : p[2*`XLEN-1:`XLEN];
    endfunction

    function automatic commit_t expect_commit(alu_req_t r);
        commit_t          c;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        c.uuid  = r.uuid;
        c.wid   = r.wid;
        c.tmask = r.tmask;
        c.pc    = r.pc;
        c.rd    = r.rd;
        c.wb    = r.wb;
        for (int i = 0; i < `NUM_THREADS; i++) begin
            a = r.use_pc ? r.pc : r.rs1_data[i];
            b = r.use_imm ? r.imm : r.rs2_data[i];
            case (r.op_class)
                OP_MUL:  c.data[i] = mul_ref(mul_op_e'(r.op[1:0]), r.rs1_data[i], r.rs2_data[i]);
                OP_BR:   c.data[i] = r.next_pc;   // Link value, checked only when wb
                default: c.data[i] = alu_ref(alu_op_e'(r.op), a, r.rs1_data[i], b);
            endcase
        end
        return c;
    endfunction

    function automatic branch_t expect_branch(alu_req_t r);
        branch_t          br;
        logic [`XLEN-1:0] x;
        logic [`XLEN-1:0] y;
        x       = r.rs1_data[r.tid];
        y       = r.rs2_data[r.tid];
        br.wid  = r.wid;
        br.dest = (r.use_pc ? r.pc : x) + (r.use_imm ? r.imm : y);
        case (br_op_e'(r.op[2:0]))
            BR_BEQ:  br.taken = (x == y);
            BR_BNE:  br.taken = (x != y);
            BR_BLT:  br.taken = ($signed(x) < $signed(y));
            BR_BGE:  br.taken = !($signed(x) < $signed(y));
            BR_BLTU: br.taken = (x < y);
            BR_BGEU: br.taken = !(x < y);
            default: br.taken = 1'b1;
        endcase
        return br;
    endfunction

    // Scoreboard on the handshake edges
    always @(posedge clk) begin : scoreboard
        commit_t e;
        if (reset) begin
            prev_stall = 1'b0;
        end else begin
            if (prev_stall && !commit_valid) begin
                errors++;
                $display("%s: commit_valid dropped while the commit port was stalled", cur_test);
            end else if (prev_stall) begin
                check("stalled commit", prev_commit, commit);
            end
            if (branch_valid && !(commit_valid && commit_ready)) begin
                errors++;
                $display("%s: branch_valid pulsed without a commit transfer", cur_test);
            end
            if (commit_valid && commit_ready) begin
                if (exp_alu.size() > 0 && commit.uuid == exp_alu[0].uuid) begin
                    e = exp_alu.pop_front();
                    if (!e.wb)
                        e.data = commit.data;   // Data is don't care without writeback
                    check("commit", e, commit);
                    check("branch_valid", exp_isbr[0], branch_valid);
                    if (exp_isbr[0])
                        check("branch", exp_br[0], branch);
                    void'(exp_isbr.pop_front());
                    void'(exp_br.pop_front());
                end else if (exp_mul.size() > 0 && commit.uuid == exp_mul[0].uuid) begin
                    if (exp_alu.size() > 0) begin
                        errors++;
                        $display("%s: multiply result committed while an ALU result waited",
                                 cur_test);
                    end
                    e = exp_mul.pop_front();
                    check("commit", e, commit);
                end else begin
                    errors++;
                    $display("%s: commit uuid %0h matches no pending request", cur_test,
                             commit.uuid);
                end
            end
            prev_stall  = commit_valid && !commit_ready;
            prev_commit = commit;
            if (req_valid && req_ready) begin
                if (req.op_class == OP_MUL) begin
                    exp_mul.push_back(expect_commit(req));
                end else begin
                    exp_alu.push_back(expect_commit(req));
                    exp_br.push_back(expect_branch(req));
                    exp_isbr.push_back(req.op_class == OP_BR);
                end
            end
        end
    end

    task automatic build_req(output alu_req_t r, input op_class_e cls, input logic [3:0] op,
                             input logic use_pc, input logic use_imm);
        r          = '0;
        r.uuid     = next_uuid;
        next_uuid  = next_uuid + 1'b1;
        r.wid      = rand_bits(`NW_BITS);
        r.tmask    = rand_bits(`NUM_THREADS);
        r.pc       = rand_bits(32);
        r.rd       = rand_bits(`NR_BITS);
        r.wb       = (cls != OP_BR) || (op[2:0] == BR_JAL) || (op[2:0] == BR_JALR);
        r.op_class = cls;
        r.op       = op;
        r.use_pc   = use_pc;
        r.use_imm  = use_imm;
        r.imm      = rand_bits(32);
        r.tid      = rand_bits(`NT_BITS);
        r.next_pc  = r.pc + 4;
        for (int i = 0; i < `NUM_THREADS; i++) begin
            r.rs1_data[i] = rand_bits(32);
            r.rs2_data[i] = rand_bits(32);
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send(input alu_req_t r);
        int n;
        req       = r;
        req_valid = 1'b1;
        for (n = 0; n < TIMEOUT; n++) begin
            #1;
            if (req_ready)
                break;
            @(negedge clk);
        end
        if (n == TIMEOUT) begin
            timeouts++;
            $display("%s: request uuid %0h was never accepted", cur_test, r.uuid);
        end else begin
            @(negedge clk);
        end
        req_valid = 1'b0;
    endtask

    task automatic drain();
        int n;
        for (n = 0; n < TIMEOUT; n++) begin
            if (exp_alu.size() == 0 && exp_mul.size() == 0)
                break;
            @(negedge clk);
        end
        if (n == TIMEOUT) begin
            timeouts++;
            $display("%s: %0d ALU and %0d multiply results never committed", cur_test,
                     exp_alu.size(), exp_mul.size());
            exp_alu.delete();
            exp_br.delete();
            exp_isbr.delete();
            exp_mul.delete();
        end
    endtask

    task automatic test_reset();
        cur_test = "test_reset";
        repeat (3) begin
            @(negedge clk);
            check("commit_valid", 1'b0, commit_valid);
            check("branch_valid", 1'b0, branch_valid);
        end
        reset = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check("commit_valid", 1'b0, commit_valid);
            check("branch_valid", 1'b0, branch_valid);
        end
    endtask

    task automatic test_alu_ops();
        alu_req_t r;
        cur_test = "test_alu_ops";
        for (int op = 0; op < 10; op++) begin
            for (int m = 0; m < 4; m++) begin
                build_req(r, OP_ALU, 4'(op), m[0], m[1]);
                send(r);
            end
        end
        drain();
    endtask

    task automatic test_branches();
        alu_req_t         r;
        logic [`XLEN-1:0] x;
        cur_test = "test_branches";
        for (int op = 0; op < 6; op++) begin
            for (int rel = 0; rel < 4; rel++) begin
                build_req(r, OP_BR, 4'(op), 1'b1, 1'b1);
                x = r.rs1_data[r.tid];
                case (rel)
                    0:       r.rs2_data[r.tid] = x;
                    1:       r.rs2_data[r.tid] = x + 1;
                    2:       r.rs2_data[r.tid] = x - 1;
                    default: r.rs2_data[r.tid] = x ^ 32'h8000_0000;   // Signs differ
                endcase
                send(r);
            end
        end
        build_req(r, OP_BR, 4'(BR_JAL), 1'b1, 1'b1);
        send(r);
        build_req(r, OP_BR, 4'(BR_JALR), 1'b0, 1'b1);
        send(r);
        drain();
    endtask

    task automatic test_mul();
        alu_req_t         r;
        logic [`XLEN-1:0] corner [5];
        cur_test = "test_mul";
        corner = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        for (int op = 0; op < 4; op++) begin
            for (int k = 0; k < 7; k++) begin
                build_req(r, OP_MUL, 4'(op), 1'b0, 1'b0);
                if (k < 5) begin   // Last two stay random
                    for (int i = 0; i < `NUM_THREADS; i++) begin
                        r.rs1_data[i] = corner[(i + k) % 5];
                        r.rs2_data[i] = corner[(3 * i + 2 * k) % 5];
                    end
                end
                send(r);
            end
        end
        drain();
    endtask

    task automatic test_backpressure();
        alu_req_t    r;
        alu_req_t    list[$];
        logic [31:0] kind;
        logic        stop;
        cur_test = "test_backpressure";
        stop     = 1'b0;
        for (int k = 0; k < 40; k++) begin
            kind = rand_bits(2);
            case (kind[1:0])
                2'd0:    build_req(r, OP_MUL, 4'(rand_bits(2)), 1'b0, 1'b0);
                2'd1:    build_req(r, OP_BR, 4'(rand_bits(3)), rand_bits(1), rand_bits(1));
                default: build_req(r, OP_ALU, 4'(rand_bits(4) % 10), rand_bits(1),
                                   rand_bits(1));
            endcase
            list.push_back(r);
        end
        fork
            begin
                foreach (list[k])
                    send(list[k]);
                drain();
                stop = 1'b1;
            end
            begin
                for (int n = 0; n < 40 * TIMEOUT && !stop; n++) begin
                    @(negedge clk);
                    commit_ready = rand_bits(1);
                end
            end
        join
        commit_ready = 1'b1;
    endtask

    initial begin
        reset        = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        commit_ready = 1'b1;
        test_reset();
        test_alu_ops();
        test_branches();
        test_mul();
        test_backpressure();
        repeat (4) @(negedge clk);   // Catch stray commits
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule
